/* design/id_pkg.sv */
package id_pkg;

   ///////////////////////////////////////////////////////////////////////
   // Widths
   ///////////////////////////////////////////////////////////////////////

   // Program counter width seen by the decode stage
   localparam int PC_W = 16;

   typedef logic [31:0]     word_t;
   typedef logic [4:0]      reg_idx_t;
   typedef logic [PC_W-1:0] pc_t;
   typedef logic [6:0]      opcode_t;
   typedef logic [2:0]      alu_op_t;

   ///////////////////////////////////////////////////////////////////////
   // Encodings
   ///////////////////////////////////////////////////////////////////////

   // RV32I major opcodes handled here
   localparam opcode_t OP_LUI    = 7'b0110111;
   localparam opcode_t OP_AUIPC  = 7'b0010111;
   localparam opcode_t OP_JAL    = 7'b1101111;
   localparam opcode_t OP_JALR   = 7'b1100111;
   localparam opcode_t OP_BRANCH = 7'b1100011;
   localparam opcode_t OP_LOAD   = 7'b0000011;
   localparam opcode_t OP_STORE  = 7'b0100011;
   localparam opcode_t OP_IMM    = 7'b0010011;
   localparam opcode_t OP_REG    = 7'b0110011;

   // ALU operation follows funct3 of the arithmetic groups
   localparam alu_op_t ALU_ADD  = 3'd0;
   localparam alu_op_t ALU_SLL  = 3'd1;
   localparam alu_op_t ALU_SLT  = 3'd2;
   localparam alu_op_t ALU_SLTU = 3'd3;
   localparam alu_op_t ALU_XOR  = 3'd4;
   localparam alu_op_t ALU_SR   = 3'd5;
   localparam alu_op_t ALU_OR   = 3'd6;
   localparam alu_op_t ALU_AND  = 3'd7;

   ///////////////////////////////////////////////////////////////////////
   // Bundles
   ///////////////////////////////////////////////////////////////////////

   // Fetched instruction with its operands
   typedef struct packed {
      word_t instr;
      pc_t   pc;
      word_t rs1_val;
      word_t rs2_val;
   } if_id_s;

   // Execute and memory controls
   typedef struct packed {
      alu_op_t    alu_op;
      logic       sub_sra;
      logic       alusrc;
      logic       memread;
      logic       memwrite;
      logic       regwrite;
      logic [2:0] mem_size;
      logic       branch;
      logic       jal;
      logic       jalr;
      logic       lui;
      logic       auipc;
      logic       valid;
   } ctrl_s;

   // Later stages feeding back into decode
   typedef struct packed {
      reg_idx_t ex_mem_rd;
      logic     ex_mem_regwrite;
      logic     ex_mem_memread;
      word_t    ex_mem_alures;
      reg_idx_t mem_wb_rd;
      logic     mem_wb_regwrite;
      word_t    wb_res;
   } fwd_s;

   // Source index hits, x0 excluded
   typedef struct packed {
      logic rs1_ex;
      logic rs2_ex;
      logic rs1_mem;
      logic rs2_mem;
   } dep_s;

   typedef struct packed {
      reg_idx_t rs1;
      reg_idx_t rs2;
      word_t    rs1_fwd;
      word_t    rs2_fwd;
      word_t    imm;
      dep_s     dep;
   } oper_s;

   // ID/EX pipeline register contents
   typedef struct packed {
      ctrl_s    ctrl;
      pc_t      pc;
      reg_idx_t rs1;
      reg_idx_t rs2;
      reg_idx_t rd;
      word_t    rs1_val;
      word_t    rs2_val;
      word_t    imm;
   } id_ex_s;

endpackage

/* design/id_ctrl_decode.sv */
`timescale 1ns/10ps

module id_ctrl_decode (
   input  id_pkg::word_t instr,
   input  logic          flush,
   output id_pkg::ctrl_s ctrl
);
   import id_pkg::*;

   opcode_t    opcode;
   logic [2:0] funct3;
   logic       f7_b5;

   // Instruction fields
   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign f7_b5  = instr[30];

   ///////////////////////////////////////////////////////////////////////
   // Opcode decode
   ///////////////////////////////////////////////////////////////////////

   always_comb begin
      // Default is a bubble, also for zero and unknown words
      ctrl = '0;
      if (!flush) begin
         case (opcode)
            OP_LUI: begin
               ctrl.alusrc   = 1'b1;
               ctrl.regwrite = 1'b1;
               ctrl.lui      = 1'b1;
               ctrl.valid    = 1'b1;
            end
            OP_AUIPC: begin
               ctrl.alusrc   = 1'b1;
               ctrl.regwrite = 1'b1;
               ctrl.auipc    = 1'b1;
               ctrl.valid    = 1'b1;
            end
            OP_JAL: begin
               ctrl.alusrc   = 1'b1;
               ctrl.regwrite = 1'b1;
               ctrl.jal      = 1'b1;
               ctrl.valid    = 1'b1;
            end
            OP_JALR: begin
               ctrl.alusrc   = 1'b1;
               ctrl.regwrite = 1'b1;
               ctrl.jalr     = 1'b1;
               ctrl.valid    = 1'b1;
            end
            OP_BRANCH: begin
               // Compare happens here, ALU only sees an add
               ctrl.branch = 1'b1;
               ctrl.valid  = 1'b1;
            end
            OP_LOAD: begin
               ctrl.alusrc   = 1'b1;
               ctrl.memread  = 1'b1;
               ctrl.regwrite = 1'b1;
               ctrl.mem_size = funct3;
               ctrl.valid    = 1'b1;
            end
            OP_STORE: begin
               ctrl.alusrc   = 1'b1;
               ctrl.memwrite = 1'b1;
               ctrl.mem_size = funct3;
               ctrl.valid    = 1'b1;
            end
            OP_IMM: begin
               ctrl.alu_op   = alu_op_t'(funct3);
               // Only shifts carry funct7 in the immediate form
               ctrl.sub_sra  = (funct3 == ALU_SLL || funct3 == ALU_SR) ? f7_b5 : 1'b0;
               ctrl.alusrc   = 1'b1;
               ctrl.regwrite = 1'b1;
               ctrl.valid    = 1'b1;
            end
            OP_REG: begin
               ctrl.alu_op   = alu_op_t'(funct3);
               ctrl.sub_sra  = f7_b5;
               ctrl.regwrite = 1'b1;
               ctrl.valid    = 1'b1;
            end
            default: begin
               ctrl = '0;
            end
         endcase
      end
   end

endmodule

/* design/id_operand_fwd.sv */
`timescale 1ns/10ps

module id_operand_fwd (
   input  id_pkg::word_t    instr,
   input  id_pkg::word_t    rs1_val,
   input  id_pkg::word_t    rs2_val,
   input  id_pkg::fwd_s     fwd,
   input  id_pkg::reg_idx_t ex_rd,
   input  logic             ex_regwrite,
   output id_pkg::oper_s    oper
);
   import id_pkg::*;

   opcode_t  opcode;
   reg_idx_t rs1;
   reg_idx_t rs2;

   // Pick the youngest available value for one source
   function automatic word_t pick_operand(input reg_idx_t idx, input word_t raw,
                                          input fwd_s f);
      logic ex_hit;
      logic wb_hit;
      ex_hit = (idx != '0) && (idx == f.ex_mem_rd) && f.ex_mem_regwrite &&
               !f.ex_mem_memread;
      wb_hit = (idx != '0) && (idx == f.mem_wb_rd) && f.mem_wb_regwrite;
      // EX/MEM wins over MEM/WB
      if (ex_hit) begin
         return f.ex_mem_alures;
      end
      if (wb_hit) begin
         return f.wb_res;
      end
      return raw;
   endfunction

   assign opcode = instr[6:0];
   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];

   ///////////////////////////////////////////////////////////////////////
   // Indices and forwarding
   ///////////////////////////////////////////////////////////////////////

   assign oper.rs1     = rs1;
   assign oper.rs2     = rs2;
   assign oper.rs1_fwd = pick_operand(rs1, rs1_val, fwd);
   assign oper.rs2_fwd = pick_operand(rs2, rs2_val, fwd);

   // Hits against the ID/EX writer
   assign oper.dep.rs1_ex = (rs1 != '0) && (rs1 == ex_rd) && ex_regwrite;
   assign oper.dep.rs2_ex = (rs2 != '0) && (rs2 == ex_rd) && ex_regwrite;

   // Hits against EX/MEM, qualified later with its memread
   assign oper.dep.rs1_mem = (rs1 != '0) && (rs1 == fwd.ex_mem_rd);
   assign oper.dep.rs2_mem = (rs2 != '0) && (rs2 == fwd.ex_mem_rd);

   ///////////////////////////////////////////////////////////////////////
   // Immediate generation
   ///////////////////////////////////////////////////////////////////////

   always_comb begin
      case (opcode)
         // I format
         OP_LOAD, OP_IMM, OP_JALR: begin
            oper.imm = {{20{instr[31]}}, instr[31:20]};
         end
         // S format
         OP_STORE: begin
            oper.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
         end
         // B format, halfword aligned
         OP_BRANCH: begin
            oper.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                        instr[11:8], 1'b0};
         end
         OP_LUI, OP_AUIPC: begin
            oper.imm = {instr[31:12], 12'h000};
         end
         // J format
         OP_JAL: begin
            oper.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                        instr[30:21], 1'b0};
         end
         default: begin
            oper.imm = '0;
         end
      endcase
   end

endmodule

/* design/id_issue.sv */
`timescale 1ns/10ps

module id_issue #(
   parameter int PC_W = id_pkg::PC_W
) (
   input  logic           bus,
   input  logic           rst_n,
   input  logic           freeze,
   input  id_pkg::word_t  instr,
   input  id_pkg::pc_t    pc,
   input  id_pkg::word_t  rs1_val,
   input  id_pkg::word_t  rs2_val,
   input  id_pkg::ctrl_s  ctrl,
   input  id_pkg::oper_s  oper,
   input  id_pkg::fwd_s   fwd,
   output logic           flush,
   output logic           hazard,
   output logic           branch_taken,
   output id_pkg::pc_t    branch_off,
   output id_pkg::id_ex_s id_ex
);
   import id_pkg::*;

   logic       reads_branch;
   logic       used_ex;
   logic       used_mem;
   logic       load_use;
   logic       cond_true;
   logic [2:0] funct3;
   word_t      jalr_tgt;
   id_ex_s     id_ex_nxt;

   assign funct3 = instr[14:12];

   ///////////////////////////////////////////////////////////////////////
   // Hazard detection
   ///////////////////////////////////////////////////////////////////////

   // rs2 only counts when the second operand is a register
   assign used_ex  = oper.dep.rs1_ex || (oper.dep.rs2_ex && !ctrl.alusrc);
   assign used_mem = oper.dep.rs1_mem || (oper.dep.rs2_mem && !ctrl.alusrc);

   // Branch and jalr need final operands in decode
   assign reads_branch = ctrl.branch || ctrl.jalr;

   assign load_use = id_ex.ctrl.memread && used_ex;

   // ID/EX writer or an EX/MEM load still in flight
   assign hazard = load_use ||
                   (reads_branch && used_ex) ||
                   (reads_branch && fwd.ex_mem_memread && used_mem);

   ///////////////////////////////////////////////////////////////////////
   // Branch resolution
   ///////////////////////////////////////////////////////////////////////

   always_comb begin
      case (funct3)
         3'b000:  cond_true = (oper.rs1_fwd == oper.rs2_fwd);
         3'b001:  cond_true = (oper.rs1_fwd != oper.rs2_fwd);
         3'b100:  cond_true = ($signed(oper.rs1_fwd) < $signed(oper.rs2_fwd));
         3'b101:  cond_true = ($signed(oper.rs1_fwd) >= $signed(oper.rs2_fwd));
         3'b110:  cond_true = (oper.rs1_fwd < oper.rs2_fwd);
         3'b111:  cond_true = (oper.rs1_fwd >= oper.rs2_fwd);
         default: cond_true = 1'b0;
      endcase
   end

   // Flushed slot has zero controls, so it never redirects
   assign branch_taken = !hazard && (ctrl.jal || ctrl.jalr || (ctrl.branch && cond_true));

   // Register target, low bit dropped as the ISA requires
   assign jalr_tgt = (oper.rs1_fwd + oper.imm) & ~word_t'(1);

   always_comb begin
      if (ctrl.branch || ctrl.jal) begin
         branch_off = oper.imm[PC_W-1:0];
      end else if (ctrl.jalr) begin
         branch_off = jalr_tgt[PC_W-1:0];
      end else begin
         branch_off = '0;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // ID/EX register
   ///////////////////////////////////////////////////////////////////////

   always_comb begin
      id_ex_nxt = '0;
      if (hazard) begin
         // Stall bubble keeps the pc
         id_ex_nxt.ctrl.alusrc = 1'b1;
         id_ex_nxt.pc          = pc;
      end else if (ctrl.valid) begin
         id_ex_nxt.ctrl    = ctrl;
         id_ex_nxt.pc      = pc;
         id_ex_nxt.rs1     = oper.rs1;
         id_ex_nxt.rs2     = oper.rs2;
         id_ex_nxt.rd      = instr[11:7];
         // Execute forwards on its own
         id_ex_nxt.rs1_val = rs1_val;
         id_ex_nxt.rs2_val = rs2_val;
         id_ex_nxt.imm     = oper.imm;
      end
   end

   always_ff @(posedge bus) begin
      if (!rst_n) begin
         id_ex <= '0;
         flush <= 1'b0;
      end else if (!freeze) begin
         id_ex <= id_ex_nxt;
         // Squash the slot behind a redirect
         flush <= branch_taken;
      end
   end

endmodule

/* design/id_stage.sv */
`timescale 1ns/10ps

module id_stage #(
   parameter int PC_W = id_pkg::PC_W
) (
   input  logic           bus,
   input  logic           rst_n,
   input  logic           freeze,
   input  id_pkg::if_id_s if_id,
   input  id_pkg::fwd_s   fwd,
   output id_pkg::id_ex_s id_ex,
   output logic           hazard,
   output logic           branch_taken,
   output id_pkg::pc_t    branch_off
);
   import id_pkg::*;

   ctrl_s ctrl;
   oper_s oper;
   logic  flush;

   ///////////////////////////////////////////////////////////////////////
   // Decode and operand paths
   ///////////////////////////////////////////////////////////////////////

   id_ctrl_decode u_ctrl (
      .instr (if_id.instr),
      .flush (flush),
      .ctrl  (ctrl)
   );

   // Reads the destination currently held in ID/EX
   id_operand_fwd u_oper (
      .instr       (if_id.instr),
      .rs1_val     (if_id.rs1_val),
      .rs2_val     (if_id.rs2_val),
      .fwd         (fwd),
      .ex_rd       (id_ex.rd),
      .ex_regwrite (id_ex.ctrl.regwrite),
      .oper        (oper)
   );

   // Hazard, branch and pipeline register
   id_issue #(
      .PC_W (PC_W)
   ) u_issue (
      .bus          (bus),
      .rst_n        (rst_n),
      .freeze       (freeze),
      .instr        (if_id.instr),
      .pc           (if_id.pc),
      .rs1_val      (if_id.rs1_val),
      .rs2_val      (if_id.rs2_val),
      .ctrl         (ctrl),
      .oper         (oper),
      .fwd          (fwd),
      .flush        (flush),
      .hazard       (hazard),
      .branch_taken (branch_taken),
      .branch_off   (branch_off),
      .id_ex        (id_ex)
   );

endmodule

/* tb/id_stage_sva.sv */
`timescale 1ns/10ps

module id_stage_sva (
   input logic           bus,
   input logic           rst_n,
   input logic           freeze,
   input logic           hazard,
   input id_pkg::id_ex_s id_ex
);
   import id_pkg::*;

   // Stall bubble never writes a register
   a_hazard_bubble: assert property (@(posedge bus) disable iff (!rst_n)
      (hazard && !freeze) |=> !id_ex.ctrl.regwrite)
      else $error("hazard did not load a bubble");

   // Freeze holds the whole ID/EX register
   a_freeze_hold: assert property (@(posedge bus) disable iff (!rst_n)
      freeze |=> $stable(id_ex))
      else $error("id_ex changed under freeze");

   a_reset_zero: assert property (@(posedge bus)
      !rst_n |=> (id_ex == '0))
      else $error("id_ex not cleared by reset");

endmodule

bind id_issue id_stage_sva u_sva (
   .bus    (bus),
   .rst_n  (rst_n),
   .freeze (freeze),
   .hazard (hazard),
   .id_ex  (id_ex)
);

/* tb/id_stage_tb.sv */
`timescale 1ns/10ps

module id_stage_tb;
   import id_pkg::*;

   localparam int CLK_PERIOD      = 4;
   localparam int N_TESTS         = 6;
   localparam int CYCLES_PER_TEST = 200;

   logic   bus;
   logic   rst_n;
   logic   freeze;
   if_id_s if_id;
   fwd_s   fwd;
   id_ex_s id_ex;
   logic   hazard;
   logic   branch_taken;
   pc_t    branch_off;
   pc_t    pc_cnt;
   integer seed;

   id_stage #(.PC_W(PC_W)) dut (
      .bus (bus), .rst_n (rst_n), .freeze (freeze), .if_id (if_id), .fwd (fwd),
      .id_ex (id_ex), .hazard (hazard), .branch_taken (branch_taken),
      .branch_off (branch_off)
   );

   initial begin
      bus = 1'b0;
      forever #(CLK_PERIOD / 2) bus = ~bus;
   end

   ///////////////////////////////////////////////////////////////////////
   // Reporting and compare tasks
   ///////////////////////////////////////////////////////////////////////

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("Some tests failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_entry(input string name, input id_ex_s exp, input id_ex_s act);
      if (act !== exp)
         report_fail($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_ctrl(input string name, input ctrl_s exp, input ctrl_s act);
      if (act !== exp)
         report_fail($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp)
         report_fail($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_pc(input string name, input pc_t exp, input pc_t act);
      if (act !== exp)
         report_fail($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
         report_fail($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Reference encoding
   ///////////////////////////////////////////////////////////////////////

   function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd, input opcode_t op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic word_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
   endfunction

   function automatic word_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
   endfunction

   // Controls expected from opcode, funct3 and funct7 bit 5
   function automatic ctrl_s expected_ctrl(input word_t instr);
      ctrl_s c;
      c = '0;
      c.valid = 1'b1;
      case (instr[6:0])
         OP_LUI:    {c.alusrc, c.regwrite, c.lui} = 3'b111;
         OP_AUIPC:  {c.alusrc, c.regwrite, c.auipc} = 3'b111;
         OP_JAL:    {c.alusrc, c.regwrite, c.jal} = 3'b111;
         OP_JALR:   {c.alusrc, c.regwrite, c.jalr} = 3'b111;
         OP_BRANCH: c.branch = 1'b1;
         OP_LOAD: begin
            {c.alusrc, c.memread, c.regwrite} = 3'b111;
            c.mem_size = instr[14:12];
         end
         OP_STORE: begin
            {c.alusrc, c.memwrite} = 2'b11;
            c.mem_size = instr[14:12];
         end
         OP_IMM: begin
            c.alu_op  = instr[14:12];
            c.sub_sra = (instr[13:12] == 2'b01) && instr[30];
            {c.alusrc, c.regwrite} = 2'b11;
         end
         OP_REG: begin
            c.alu_op   = instr[14:12];
            c.sub_sra  = instr[30];
            c.regwrite = 1'b1;
         end
         default: c = '0;
      endcase
      return c;
   endfunction

   // Full entry for the instruction now on if_id
   function automatic id_ex_s make_entry(input word_t imm);
      id_ex_s e;
      e      = '0;
      e.ctrl = expected_ctrl(if_id.instr);
      // Unknown opcodes leave the whole entry empty
      if (e.ctrl.valid) begin
         e.pc      = if_id.pc;
         e.rs1     = if_id.instr[19:15];
         e.rs2     = if_id.instr[24:20];
         e.rd      = if_id.instr[11:7];
         e.rs1_val = if_id.rs1_val;
         e.rs2_val = if_id.rs2_val;
         e.imm     = imm;
      end
      return e;
   endfunction

   function automatic logic cond_holds(input logic [2:0] f3, input word_t a, input word_t b);
      case (f3)
         3'b000:  return a == b;
         3'b001:  return a != b;
         3'b100:  return $signed(a) < $signed(b);
         3'b101:  return $signed(a) >= $signed(b);
         3'b110:  return a < b;
         default: return a >= b;
      endcase
   endfunction

   ///////////////////////////////////////////////////////////////////////
   // Stimulus
   ///////////////////////////////////////////////////////////////////////

   task automatic present(input word_t instr, input fwd_s f);
      word_t v1;
      word_t v2;
      v1 = $random(seed);
      v2 = $random(seed);
      @(posedge bus);
      if_id.instr   <= instr;
      if_id.pc      <= pc_cnt;
      // x0 always reads as zero from the register file
      if_id.rs1_val <= (instr[19:15] == 5'd0) ? '0 : v1;
      if_id.rs2_val <= (instr[24:20] == 5'd0) ? '0 : v2;
      fwd           <= f;
      pc_cnt        <= pc_cnt + 16'd4;
   endtask

   // One edge later the entry must sit in id_ex
   task automatic issue_and_check(input string name, input word_t instr, input word_t imm);
      id_ex_s exp;
      present(instr, '0);
      @(posedge bus);
      @(negedge bus);
      exp = make_entry(imm);
      check_ctrl({name, " ctrl"}, exp.ctrl, id_ex.ctrl);
      check_word({name, " imm"}, exp.imm, id_ex.imm);
      check_entry(name, exp, id_ex);
   endtask

   task automatic resolve_check(input string name, input word_t instr, input fwd_s f,
                                input logic taken, input pc_t off);
      present(instr, f);
      @(negedge bus);
      check_bit({name, " taken"}, taken, branch_taken);
      check_pc({name, " offset"}, off, branch_off);
      // Hold slot absorbs the squash
      @(posedge bus);
      @(negedge bus);
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Directed tests
   ///////////////////////////////////////////////////////////////////////

   task automatic test_alu_mem();
      issue_and_check("add", {7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OP_REG}, '0);
      issue_and_check("sub", {7'h20, 5'd6, 5'd5, 3'd0, 5'd4, OP_REG}, '0);
      issue_and_check("sra", {7'h20, 5'd9, 5'd8, 3'd5, 5'd7, OP_REG}, '0);
      issue_and_check("slt", {7'h00, 5'd12, 5'd11, 3'd2, 5'd10, OP_REG}, '0);
      issue_and_check("addi", enc_i(12'hffb, 5'd14, 3'd0, 5'd13, OP_IMM), 32'hffff_fffb);
      issue_and_check("slli", enc_i(12'h003, 5'd16, 3'd1, 5'd15, OP_IMM), 32'h3);
      issue_and_check("srai", enc_i(12'h407, 5'd18, 3'd5, 5'd17, OP_IMM), 32'h407);
      issue_and_check("lw", enc_i(12'h008, 5'd20, 3'd2, 5'd19, OP_LOAD), 32'h8);
      issue_and_check("lb", enc_i(12'hffc, 5'd22, 3'd0, 5'd21, OP_LOAD), 32'hffff_fffc);
      // Store offset 12 split across the two fields
      issue_and_check("sw", {7'h00, 5'd23, 5'd24, 3'd2, 5'd12, OP_STORE}, 32'hc);
      issue_and_check("sh", {7'h7f, 5'd25, 5'd26, 3'd1, 5'd30, OP_STORE}, 32'hffff_fffe);
   endtask

   task automatic test_immediates();
      word_t r;
      logic [12:0] bi;
      r = $random(seed);
      issue_and_check("lui", {r[31:12], 5'd5, OP_LUI}, {r[31:12], 12'h000});
      r = $random(seed);
      issue_and_check("auipc", {r[31:12], 5'd6, OP_AUIPC}, {r[31:12], 12'h000});
      r = $random(seed);
      issue_and_check("store imm", {r[11:5], 5'd7, 5'd8, 3'd2, r[4:0], OP_STORE},
                      {{20{r[11]}}, r[11:0]});
      r  = $random(seed);
      bi = {r[12:1], 1'b0};
      issue_and_check("branch imm", enc_b(bi, 5'd9, 5'd27, 3'd0), {{19{bi[12]}}, bi});
      issue_and_check("unknown", {25'h1abcde, 7'b0001111}, '0);
   endtask

   task automatic test_load_use();
      id_ex_s bub;
      issue_and_check("load", enc_i(12'h010, 5'd1, 3'd2, 5'd6, OP_LOAD), 32'h10);
      present({7'h00, 5'd2, 5'd6, 3'd0, 5'd7, OP_REG}, '0);
      @(negedge bus);
      check_bit("load-use hazard", 1'b1, hazard);
      bub = '0;
      bub.ctrl.alusrc = 1'b1;
      bub.pc          = if_id.pc;
      @(posedge bus);
      @(negedge bus);
      check_entry("stall bubble", bub, id_ex);
      check_bit("hazard cleared", 1'b0, hazard);
      @(posedge bus);
      @(negedge bus);
      check_entry("held add", make_entry('0), id_ex);
   endtask

   task automatic test_branches();
      logic [2:0] conds [6];
      fwd_s       f;
      word_t      a;
      word_t      b;
      word_t      r;
      logic [12:0] bi;
      logic [20:0] ji;
      conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
      for (int t = 0; t < 12; t++) begin
         a  = $random(seed);
         b  = (t % 2 == 1) ? a : word_t'($random(seed));
         r  = $random(seed);
         bi = {r[12:1], 1'b0};
         // rs1 from EX/MEM, rs2 from MEM/WB
         f = '0;
         f.ex_mem_rd = 5'd10;
         f.ex_mem_regwrite = 1'b1;
         f.ex_mem_alures = a;
         f.mem_wb_rd = 5'd11;
         f.mem_wb_regwrite = 1'b1;
         f.wb_res = b;
         resolve_check($sformatf("branch f3=%0d", conds[t / 2]),
                       enc_b(bi, 5'd11, 5'd10, conds[t / 2]), f,
                       cond_holds(conds[t / 2], a, b), pc_t'({{19{bi[12]}}, bi}));
      end
      // Same index in both stages, EX/MEM must win
      a = $random(seed);
      f.mem_wb_rd = 5'd10;
      f.ex_mem_alures = a;
      f.wb_res = ~a;
      resolve_check("ex/mem priority", enc_i(12'h010, 5'd10, 3'd0, 5'd1, OP_JALR), f, 1'b1,
                    pc_t'((a + 32'h10) & 32'hffff_fffe));
      r  = $random(seed);
      ji = {r[20:1], 1'b0};
      resolve_check("jal", enc_j(ji, 5'd1), '0, 1'b1, pc_t'({{11{ji[20]}}, ji}));
      f.mem_wb_regwrite = 1'b0;
      resolve_check("jalr", enc_i(12'hff5, 5'd10, 3'd0, 5'd1, OP_JALR), f, 1'b1,
                    pc_t'((a + 32'hffff_fff5) & 32'hffff_fffe));
   endtask

   task automatic test_flush();
      resolve_check("beq x0", enc_b(13'h020, 5'd0, 5'd0, 3'd0), '0, 1'b1, 16'h20);
      present(enc_b(13'h040, 5'd0, 5'd0, 3'd0), '0);
      @(negedge bus);
      check_bit("taken before squash", 1'b1, branch_taken);
      present(enc_j(21'h00100, 5'd2), '0);
      @(negedge bus);
      // Jump in the shadow must not redirect
      check_bit("squashed jal", 1'b0, branch_taken);
      @(posedge bus);
      @(negedge bus);
      check_entry("squash bubble", '0, id_ex);
      // Replace the held jump with an empty word before moving on
      present('0, '0);
   endtask

   task automatic test_freeze_reset();
      id_ex_s exp;
      issue_and_check("pre-freeze", enc_i(12'h123, 5'd3, 3'd6, 5'd4, OP_IMM), 32'h123);
      exp = make_entry(32'h123);
      @(posedge bus);
      freeze <= 1'b1;
      if_id.instr <= {7'h00, 5'd2, 5'd1, 3'd7, 5'd9, OP_REG};
      repeat (3) @(posedge bus);
      @(negedge bus);
      check_entry("frozen", exp, id_ex);
      @(posedge bus);
      freeze <= 1'b0;
      rst_n  <= 1'b0;
      @(posedge bus);
      @(negedge bus);
      check_entry("after reset", '0, id_ex);
      @(posedge bus);
      rst_n <= 1'b1;
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Main sequence and watchdog
   ///////////////////////////////////////////////////////////////////////

   initial begin
      #(N_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
      report_fail("Watchdog expired before the tests finished");
   end

   initial begin
      seed   = 32'haf1a;
      rst_n  = 1'b0;
      freeze = 1'b0;
      if_id  = '0;
      fwd    = '0;
      pc_cnt = 16'h0100;
      repeat (10) @(posedge bus);
      rst_n <= 1'b1;
      test_alu_mem();
      test_immediates();
      test_load_use();
      test_branches();
      test_flush();
      test_freeze_reset();
      $display("All tests passed");
      $finish;
   end

endmodule

/* list.f */
design/id_pkg.sv
design/id_ctrl_decode.sv
design/id_operand_fwd.sv
design/id_issue.sv
design/id_stage.sv
tb/id_stage_sva.sv
tb/id_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= id_stage_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Some tests failed
PASS_MSG  ?= All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) --binary --timing --assert -f $(FILE_LIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
